// ==== parity_patterns.txt ====
// columns: pad count P, tap mask T, seed S, message LFSR seed, all hex
// one run per line, P from 01 to 40
08 b8 5c 53
01 8e 01 a7
40 ff 81 3c
10 00 ff 11
20 1d 00 e2
05 63 a5 7f
3f 96 3c 01
02 c3 7e 9d

// ==== parity_cpu.f ====
+incdir+.
cpu_pkg.sv
cpu_ctrl.sv
program_table.sv
reg_file.sv
alu.sv
data_mem.sv
parity_cpu_top.sv
tb_clock.sv
parity_cpu_checker.sv
tb_parity_cpu.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_parity_cpu
RTL_TOP   ?= parity_cpu_top
FILELIST  ?= parity_cpu.f
BUILD     ?= obj_dir
LOG       ?= sim.log
TSCALE    ?= --timescale 1ns/1ps
VFLAGS    ?= --assert -Wno-fatal
RUNFLAGS  ?= +verilator+error+limit+100

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall --timing $(TSCALE) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(TSCALE) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) $(RUNFLAGS) | tee $(LOG)
	grep -q "^Regression passed$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== tb_parity_cpu.sv ====
`include "parity_cpu_settings.svh"

module tb_parity_cpu;
	timeunit 1ns;
	timeprecision 1ps;
	import cpu_pkg::*;

	localparam int MAX_RUNS   = 16;
	localparam int WAIT_LIMIT = 4000;
	localparam int POLL_LIMIT = 100;

	logic                   clk;
	logic                   arst_n;
	logic                   psel;
	logic                   penable;
	logic                   pwrite;
	logic [`APB_ADDR_W-1:0] paddr;
	byte_t                  pwdata;
	byte_t                  prdata;
	logic                   pready;
	logic                   pslverr;

	// four bytes per run with pad count, taps, seed and message lfsr seed
	logic [7:0] patterns [0:4*MAX_RUNS-1];
	// expected memory contents
	byte_t      image [`MEM_DEPTH];
	byte_t      msg_lfsr;
	int         checks;
	int         errors;
	logic       timed_out;

	tb_clock clock_gen (
		.clk    (clk),
		.arst_n (arst_n)
	);

	parity_cpu_top UUT (
		.clk     (clk),
		.arst_n  (arst_n),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr)
	);

	// right-shifting galois register with taps 0xb8
	function automatic byte_t galois_step(input byte_t s);
		return s[0] ? ((s >> 1) ^ 8'hb8) : (s >> 1);
	endfunction

	// scrambler state update shifts the parity of masked state in at bit 0
	function automatic byte_t scrambler_next(input byte_t s, input byte_t taps);
		return {s[6:0], ^(s & taps)};
	endfunction

	task automatic next_random_byte(output byte_t value);
		value = '0;
		for (int k = 0; k < 8; k++) begin
			value = {value[6:0], msg_lfsr[0]};
			msg_lfsr = galois_step(msg_lfsr);
		end
	endtask

	task automatic check_value(input byte_t got, input byte_t expected, input string what);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("ERROR at %0d ns: %s gave %h, expected %h", $time, what, got, expected);
		end
	endtask

	// called 1 ns after a rising edge and returns 1 ns after the completing edge
	task automatic apb_transfer(input logic write, input int addr, input byte_t wdata,
			output byte_t rdata, output int stalls);
		logic ready;
		ready = 1'b0;
		stalls = 0;
		rdata = '0;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = write;
		paddr = addr[`APB_ADDR_W-1:0];
		pwdata = wdata;
		@(posedge clk);
		#1;
		penable = 1'b1;
		while (!ready && !timed_out) begin
			// pready and prdata are settled mid-cycle
			@(negedge clk);
			ready = pready;
			rdata = prdata;
			@(posedge clk);
			#1;
			if (!ready) begin
				stalls++;
				if (stalls > WAIT_LIMIT) begin
					timed_out = 1'b1;
					$display("timeout: pready stayed low at address %0h", addr);
				end
			end
		end
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apb_write(input int addr, input byte_t data);
		byte_t unused_rdata;
		int    unused_stalls;
		apb_transfer(1'b1, addr, data, unused_rdata, unused_stalls);
	endtask

	task automatic apb_read(input int addr, output byte_t data);
		int unused_stalls;
		apb_transfer(1'b0, addr, 8'h00, data, unused_stalls);
	endtask

	task automatic run_pattern(input int n);
		int    pad;
		int    last;
		int    stalls;
		int    polls;
		byte_t taps;
		byte_t state;
		byte_t value;
		pad = int'(patterns[4*n]);
		taps = patterns[4*n+1];
		msg_lfsr = patterns[4*n+3];
		last = `OUT_BASE + pad + `MSG_LEN - 1;
		// message bytes plus the two spare bytes below the pad count
		for (int i = 0; i < `PAD_ADDR; i++) begin
			next_random_byte(value);
			image[i] = value;
		end
		image[`PAD_ADDR] = patterns[4*n];
		image[`TAP_ADDR] = taps;
		image[`SEED_ADDR] = patterns[4*n+2];
		for (int i = 0; i < `OUT_BASE; i++) begin
			apb_write(i, image[i]);
		end
		for (int i = 0; i < `OUT_BASE; i++) begin
			apb_read(i, value);
			check_value(value, image[i], "input round trip");
		end
		state = patterns[4*n+2];
		for (int i = 0; i < pad; i++) begin
			image[`OUT_BASE + i] = state ^ 8'h20;
			state = scrambler_next(state, taps);
		end
		for (int i = 0; i < `MSG_LEN; i++) begin
			image[`OUT_BASE + pad + i] = image[i] ^ state;
			state = scrambler_next(state, taps);
		end

		apb_write(`CSR_ADDR, 8'h01);
		apb_read(`CSR_ADDR, value);
		check_value(value, 8'h01, "status after start");
		// held off until the run ends
		apb_transfer(1'b0, last, 8'h00, value, stalls);
		if (timed_out) begin
			return;
		end
		check_value(value, image[last], "stalled read");
		check_value(byte_t'(stalls > 0), 8'h01, "read stalled during run");

		polls = 0;
		value = '0;
		while (!value[1] && !timed_out) begin
			apb_read(`CSR_ADDR, value);
			polls++;
			if (polls > POLL_LIMIT) begin
				timed_out = 1'b1;
				$display("timeout: done never set in run %0d", n);
			end
		end
		if (timed_out) begin
			return;
		end
		check_value(value, 8'h02, "status after run");
		for (int i = 0; i <= last; i++) begin
			apb_read(i, value);
			check_value(value, image[i], $sformatf("run %0d address %0d", n, i));
		end
	endtask

	initial begin
		int runs;
		int waited;
		byte_t value;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		checks = 0;
		errors = 0;
		timed_out = 1'b0;
		runs = 0;
		waited = 0;
		for (int i = 0; i < 4*MAX_RUNS; i++) begin
			patterns[i] = '0;
		end
		$readmemh("parity_patterns.txt", patterns);

		while (arst_n !== 1'b1 && !timed_out) begin
			@(posedge clk);
			waited++;
			if (waited > 20) begin
				timed_out = 1'b1;
				$display("timeout: reset was never released");
			end
		end
		#1;
		if (!timed_out) begin
			apb_read(`CSR_ADDR, value);
			check_value(value, 8'h00, "status after reset");
		end

		// zero pad count ends the list and runs follow without a reset
		while (runs < MAX_RUNS && patterns[4*runs] != 8'h00 && !timed_out) begin
			run_pattern(runs);
			runs++;
		end
		if (runs == 0 && !timed_out) begin
			errors++;
			$display("no pattern lines could be read from parity_patterns.txt");
		end

		$display("summary: %0d runs, %0d checks, %0d errors, %0d assertion failures, timeout %0d",
			runs, checks, errors, UUT.u_checker.fail_count, timed_out);
		if (errors == 0 && !timed_out && UUT.u_checker.fail_count == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

// ==== parity_cpu_checker.sv ====
`include "parity_cpu_settings.svh"

module parity_cpu_checker (
	input logic                   clk,
	input logic                   arst_n,
	input logic                   psel,
	input logic                   penable,
	input logic [`APB_ADDR_W-1:0] paddr,
	input logic                   busy,
	input logic                   done,
	input logic                   pready,
	input logic                   pslverr
);
	timeunit 1ns;
	timeprecision 1ps;

	int fail_count = 0;

	// host memory access has to wait out a run
	a_mem_stall: assert property (@(posedge clk) disable iff (!arst_n)
		(psel && penable && !paddr[`APB_ADDR_W-1] && busy) |-> !pready)
	else begin
		fail_count++;
		$error("memory access completed while the core was busy");
	end

	a_busy_done: assert property (@(posedge clk) disable iff (!arst_n) !(busy && done))
	else begin
		fail_count++;
		$error("busy and done high together");
	end

	a_no_slverr: assert property (@(posedge clk) disable iff (!arst_n) !pslverr)
	else begin
		fail_count++;
		$error("pslverr went high");
	end

	// first sampled cycle out of reset
	a_reset_idle: assert property (@(posedge clk) $rose(arst_n) |-> !busy)
	else begin
		fail_count++;
		$error("busy high right after reset");
	end

endmodule

bind parity_cpu_top parity_cpu_checker u_checker (
	.clk     (clk),
	.arst_n  (arst_n),
	.psel    (psel),
	.penable (penable),
	.paddr   (paddr),
	.busy    (busy),
	.done    (status[1]),
	.pready  (pready),
	.pslverr (pslverr)
);

// ==== tb_clock.sv ====
module tb_clock (
	output logic clk,
	output logic arst_n
);
	timeunit 1ns;
	timeprecision 1ps;

	// 10 ns period
	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// reset held over the first two rising edges
	initial begin
		arst_n = 1'b0;
		repeat (2) @(posedge clk);
		#1;
		arst_n = 1'b1;
	end

endmodule

// ==== parity_cpu_top.sv ====
`include "parity_cpu_settings.svh"

module parity_cpu_top (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   psel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  logic [`APB_ADDR_W-1:0] paddr,
	input  cpu_pkg::byte_t         pwdata,
	output cpu_pkg::byte_t         prdata,
	output logic                   pready,
	output logic                   pslverr
);
	import cpu_pkg::*;

	pc_t       pc;
	logic      busy;
	logic      core_en;
	byte_t     status;
	alu_op_e   alu_op;
	reg_addr_t dst;
	reg_addr_t src_a;
	reg_addr_t src_b;
	byte_t     imm;
	logic      rf_write;
	logic      mem_read;
	logic      mem_write;
	byte_t     rdata_a;
	byte_t     rdata_b;
	byte_t     result;
	mem_addr_t mem_addr;
	logic      taken;
	byte_t     core_rdata;
	byte_t     mem_rdata;
	logic      mem_ready;
	byte_t     wb_data;
	logic      csr_sel;

	assign csr_sel = paddr[`APB_ADDR_W-1];

	// lb writes back the loaded byte, everything else the alu result
	assign wb_data = mem_read ? core_rdata : result;

	// status accesses never wait
	assign prdata  = csr_sel ? status : mem_rdata;
	assign pready  = csr_sel ? 1'b1 : mem_ready;
	assign pslverr = 1'b0;

	cpu_ctrl u_ctrl (
		.clk     (clk),
		.arst_n  (arst_n),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.alu_op  (alu_op),
		.imm     (imm),
		.taken   (taken),
		.pc      (pc),
		.busy    (busy),
		.core_en (core_en),
		.status  (status)
	);

	program_table u_prog (
		.pc        (pc),
		.alu_op    (alu_op),
		.dst       (dst),
		.src_a     (src_a),
		.src_b     (src_b),
		.imm       (imm),
		.rf_write  (rf_write),
		.mem_read  (mem_read),
		.mem_write (mem_write)
	);

	reg_file u_rf (
		.clk     (clk),
		.we      (rf_write && core_en),
		.waddr   (dst),
		.wdata   (wb_data),
		.raddr_a (src_a),
		.raddr_b (src_b),
		.rdata_a (rdata_a),
		.rdata_b (rdata_b)
	);

	alu u_alu (
		.alu_op   (alu_op),
		.a        (rdata_a),
		.b        (rdata_b),
		.imm      (imm),
		.result   (result),
		.mem_addr (mem_addr),
		.taken    (taken)
	);

	// sw stores the second source at base plus offset
	data_mem u_mem (
		.clk        (clk),
		.busy       (busy),
		.core_we    (mem_write && core_en),
		.core_addr  (mem_addr),
		.core_wdata (rdata_b),
		.core_rdata (core_rdata),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.paddr      (paddr),
		.pwdata     (pwdata),
		.mem_rdata  (mem_rdata),
		.mem_ready  (mem_ready)
	);

endmodule

// ==== data_mem.sv ====
`include "parity_cpu_settings.svh"

module data_mem (
	input  logic                   clk,
	input  logic                   busy,
	input  logic                   core_we,
	input  cpu_pkg::mem_addr_t     core_addr,
	input  cpu_pkg::byte_t         core_wdata,
	output cpu_pkg::byte_t         core_rdata,
	input  logic                   psel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  logic [`APB_ADDR_W-1:0] paddr,
	input  cpu_pkg::byte_t         pwdata,
	output cpu_pkg::byte_t         mem_rdata,
	output logic                   mem_ready
);
	import cpu_pkg::*;

	byte_t     mem [`MEM_DEPTH];
	mem_addr_t host_addr;
	logic      host_we;
	logic      wr_en;
	mem_addr_t wr_addr;
	byte_t     wr_data;

	assign host_addr = paddr[$clog2(`MEM_DEPTH)-1:0];
	// bit 8 low selects memory rather than the status register
	assign host_we = psel && penable && pwrite && !paddr[`APB_ADDR_W-1];

	// the core owns the single write port for the whole run
	always_comb begin
		if (busy) begin
			wr_en   = core_we;
			wr_addr = core_addr;
			wr_data = core_wdata;
		end else begin
			wr_en   = host_we;
			wr_addr = host_addr;
			wr_data = pwdata;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	assign core_rdata = mem[core_addr];
	assign mem_rdata  = mem[host_addr];

	// host stalls until the run ends
	assign mem_ready = !busy;

endmodule

// ==== alu.sv ====
module alu (
	input  cpu_pkg::alu_op_e   alu_op,
	input  cpu_pkg::byte_t     a,
	input  cpu_pkg::byte_t     b,
	input  cpu_pkg::byte_t     imm,
	output cpu_pkg::byte_t     result,
	output cpu_pkg::mem_addr_t mem_addr,
	output logic               taken
);
	import cpu_pkg::*;

	always_comb begin
		result = '0;
		taken  = 1'b0;
		case (alu_op)
			op_pass_imm: result = imm;
			op_xori:     result = a ^ imm;
			op_addi:     result = a + imm;
			op_add:      result = a + b;
			op_xor:      result = a ^ b;
			op_and:      result = a & b;
			op_or:       result = a | b;
			// only the low three bits of imm matter for a byte
			op_sll:      result = a << imm[2:0];
			// reduce to one parity bit in bit 0
			op_xorall:   result = byte_t'(^a);
			op_addr:     result = a + imm;
			op_bne:      taken = (a != b);
			op_beq:      taken = (a == b);
			default:     result = '0;
		endcase
	end

	// base register plus offset for lb and sw
	assign mem_addr = mem_addr_t'(a + imm);

endmodule

// ==== reg_file.sv ====
`include "parity_cpu_settings.svh"

module reg_file (
	input  logic               clk,
	input  logic               we,
	input  cpu_pkg::reg_addr_t waddr,
	input  cpu_pkg::byte_t     wdata,
	input  cpu_pkg::reg_addr_t raddr_a,
	input  cpu_pkg::reg_addr_t raddr_b,
	output cpu_pkg::byte_t     rdata_a,
	output cpu_pkg::byte_t     rdata_b
);
	import cpu_pkg::*;

	byte_t regs [`REG_CNT];

	always_ff @(posedge clk) begin
		if (we) begin
			regs[waddr] <= wdata;
		end
	end

	// reads see the old value during a write cycle
	assign rdata_a = regs[raddr_a];
	assign rdata_b = regs[raddr_b];

endmodule

// ==== program_table.sv ====
`include "parity_cpu_settings.svh"

module program_table (
	input  cpu_pkg::pc_t       pc,
	output cpu_pkg::alu_op_e   alu_op,
	output cpu_pkg::reg_addr_t dst,
	output cpu_pkg::reg_addr_t src_a,
	output cpu_pkg::reg_addr_t src_b,
	output cpu_pkg::byte_t     imm,
	output logic               rf_write,
	output logic               mem_read,
	output logic               mem_write
);
	import cpu_pkg::*;

	// op, dst, src_a, src_b, imm, {rf_write, mem_read, mem_write}
	logic [23:0] word;
	logic [3:0]  op_bits;

	// r0 zero, r1 taps, r2 lfsr state, r3 index, r4 limit, r7 output offset
	always_comb begin
		case (pc)
			// li r0,0
			9'd0:  word = {op_pass_imm, 3'd0, 3'd0, 3'd0, 8'd0, 3'b100};
			// lb r4,61(r0) / lb r1,62(r0) / lb r2,63(r0)
			9'd1:  word = {op_addr, 3'd4, 3'd0, 3'd0, byte_t'(`PAD_ADDR), 3'b110};
			9'd2:  word = {op_addr, 3'd1, 3'd0, 3'd0, byte_t'(`TAP_ADDR), 3'b110};
			9'd3:  word = {op_addr, 3'd2, 3'd0, 3'd0, byte_t'(`SEED_ADDR), 3'b110};
			// li r3,0
			9'd4:  word = {op_pass_imm, 3'd3, 3'd0, 3'd0, 8'd0, 3'b100};
			// preamble loop starts with xori r5,r2,32 then sw r5,64(r3)
			9'd5:  word = {op_xori, 3'd5, 3'd2, 3'd0, 8'h20, 3'b100};
			9'd6:  word = {op_addr, 3'd0, 3'd3, 3'd5, byte_t'(`OUT_BASE), 3'b001};
			// feedback bit is parity of state and taps
			9'd7:  word = {op_and, 3'd6, 3'd2, 3'd1, 8'd0, 3'b100};
			9'd8:  word = {op_xorall, 3'd6, 3'd6, 3'd0, 8'd0, 3'b100};
			9'd9:  word = {op_sll, 3'd2, 3'd2, 3'd0, 8'd1, 3'b100};
			9'd10: word = {op_or, 3'd2, 3'd2, 3'd6, 8'd0, 3'b100};
			// addi r3,r3,1 then bne r3,r4,5
			9'd11: word = {op_addi, 3'd3, 3'd3, 3'd0, 8'd1, 3'b100};
			9'd12: word = {op_bne, 3'd0, 3'd3, 3'd4, 8'd5, 3'b000};
			// add r7,r4,r0 so message output starts after the pad
			9'd13: word = {op_add, 3'd7, 3'd4, 3'd0, 8'd0, 3'b100};
			9'd14: word = {op_pass_imm, 3'd3, 3'd0, 3'd0, 8'd0, 3'b100};
			// li r4,59
			9'd15: word = {op_pass_imm, 3'd4, 3'd0, 3'd0, byte_t'(`MSG_LEN), 3'b100};
			// message loop loads with lb r5,0(r3) and xors with state
			9'd16: word = {op_addr, 3'd5, 3'd3, 3'd0, 8'd0, 3'b110};
			9'd17: word = {op_xor, 3'd5, 3'd5, 3'd2, 8'd0, 3'b100};
			// sw r5,64(r7)
			9'd18: word = {op_addr, 3'd0, 3'd7, 3'd5, byte_t'(`OUT_BASE), 3'b001};
			9'd19: word = {op_and, 3'd6, 3'd2, 3'd1, 8'd0, 3'b100};
			9'd20: word = {op_xorall, 3'd6, 3'd6, 3'd0, 8'd0, 3'b100};
			9'd21: word = {op_sll, 3'd2, 3'd2, 3'd0, 8'd1, 3'b100};
			9'd22: word = {op_or, 3'd2, 3'd2, 3'd6, 8'd0, 3'b100};
			9'd23: word = {op_addi, 3'd3, 3'd3, 3'd0, 8'd1, 3'b100};
			9'd24: word = {op_addi, 3'd7, 3'd7, 3'd0, 8'd1, 3'b100};
			// bne r3,r4,16
			9'd25: word = {op_bne, 3'd0, 3'd3, 3'd4, 8'd16, 3'b000};
			// halt entry compares r0 with itself and never branches
			default: word = {op_bne, 3'd0, 3'd0, 3'd0, 8'd0, 3'b000};
		endcase
	end

	assign {op_bits, dst, src_a, src_b, imm, rf_write, mem_read, mem_write} = word;
	assign alu_op = alu_op_e'(op_bits);

endmodule

// ==== cpu_ctrl.sv ====
`include "parity_cpu_settings.svh"

module cpu_ctrl (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   psel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  logic [`APB_ADDR_W-1:0] paddr,
	input  cpu_pkg::byte_t         pwdata,
	input  cpu_pkg::alu_op_e       alu_op,
	input  cpu_pkg::byte_t         imm,
	input  logic                   taken,
	output cpu_pkg::pc_t           pc,
	output logic                   busy,
	output logic                   core_en,
	output cpu_pkg::byte_t         status
);
	import cpu_pkg::*;

	run_state_e state;
	logic       csr_write;
	logic       start;
	logic       is_branch;
	logic       at_halt;
	logic       done;

	// start bit written in the access phase of a status transfer
	assign csr_write = psel && penable && pwrite && (paddr == `CSR_ADDR);
	// a run in progress ignores further starts
	assign start = csr_write && pwdata[0] && (state != st_run);

	assign is_branch = (alu_op == op_bne) || (alu_op == op_beq);
	assign at_halt = (pc == `HALT_PC);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= st_idle;
			pc    <= '0;
		end else if (start) begin
			state <= st_run;
			pc    <= '0;
		end else if (state == st_run) begin
			if (at_halt) begin
				state <= st_done;
			end else if (is_branch && taken) begin
				// branch target is the absolute entry in imm
				pc <= pc_t'(imm);
			end else begin
				pc <= pc + 1'b1;
			end
		end
	end

	assign busy = (state == st_run);
	assign done = (state == st_done);
	assign core_en = busy;

	// bit 0 busy, bit 1 done
	assign status = {{(`DATA_W-2){1'b0}}, done, busy};

endmodule

// ==== cpu_pkg.sv ====
`include "parity_cpu_settings.svh"

package cpu_pkg;

	typedef logic [`DATA_W-1:0]             byte_t;
	typedef logic [$clog2(`REG_CNT)-1:0]    reg_addr_t;
	typedef logic [`PC_W-1:0]               pc_t;
	typedef logic [$clog2(`MEM_DEPTH)-1:0]  mem_addr_t;

	// op_addr is the effective address add used by lb and sw
	typedef enum logic [3:0] {
		op_pass_imm,
		op_xori,
		op_addi,
		op_add,
		op_xor,
		op_and,
		op_or,
		op_sll,
		op_xorall,
		op_addr,
		op_bne,
		op_beq
	} alu_op_e;

	typedef enum logic [1:0] {
		st_idle,
		st_run,
		st_done
	} run_state_e;

endpackage

// ==== parity_cpu_settings.svh ====
`ifndef PARITY_CPU_SETTINGS_SVH
`define PARITY_CPU_SETTINGS_SVH

// datapath and storage sizes
`define DATA_W      8
`define REG_CNT     8
`define PC_W        9
`define MEM_DEPTH   256
`define APB_ADDR_W  9

// scrambler memory map
`define MSG_LEN     59
`define PAD_ADDR    61
`define TAP_ADDR    62
`define SEED_ADDR   63
`define OUT_BASE    64

// status register sits just above data memory
`define CSR_ADDR    9'h100
// first pc past the last program entry
`define HALT_PC     9'd26

`endif
